/* design/alu_pkg.sv */
package alu_pkg;

   // datapath widths
   localparam int OPERAND_W     = 64;
   localparam int SCALAR_W      = 32;
   localparam int FLAGS_W       = 6;
   localparam int LANE16_W      = 16;
   localparam int LANE32_W      = 32;
   localparam int SHIFT_COUNT_W = 5;   // count comes from b[4:0]

   // flag bit positions, shared by mask and value vectors
   localparam int FLAG_OF = 5;
   localparam int FLAG_SF = 4;
   localparam int FLAG_ZF = 3;
   localparam int FLAG_AF = 2;
   localparam int FLAG_CF = 1;
   localparam int FLAG_PF = 0;

   typedef logic [OPERAND_W-1:0] operand_t;
   typedef logic [FLAGS_W-1:0]   eflags_t;

   // codes 3, 5, 6 and 14 are free
   typedef enum logic [3:0] {
      PASS_A = 4'd0,
      ADD    = 4'd1,
      AND    = 4'd2,
      PASS_B = 4'd4,
      NOT    = 4'd7,
      OR     = 4'd8,
      PADDW  = 4'd9,
      PADDD  = 4'd10,
      PMIN   = 4'd11,
      SAL    = 4'd12,
      SAR    = 4'd13,
      PMAX   = 4'd15
   } alu_op_e;

   // anything outside these three is handled as 32 bits
   typedef enum logic [2:0] {
      SIZE_8  = 3'd1,
      SIZE_16 = 3'd2,
      SIZE_32 = 3'd3
   } opsize_e;

endpackage

/* design/alu_arith.sv */
`timescale 1ns/10ps

module alu_arith import alu_pkg::*; (
   input  operand_t a,
   input  operand_t b,
   input  opsize_e  opsize,
   output operand_t result,
   output eflags_t  flags,
   output eflags_t  flag_mask
);

   logic [8:0]          sum8;        // msb is the carry out
   logic [16:0]         sum16;
   logic [SCALAR_W:0]   sum32;
   logic [4:0]          nibble_sum;  // half carry source
   logic                of8;
   logic                of16;
   logic                of32;

   assign sum8  = {1'b0, a[7:0]} + {1'b0, b[7:0]};
   assign sum16 = {1'b0, a[15:0]} + {1'b0, b[15:0]};
   assign sum32 = {1'b0, a[SCALAR_W-1:0]} + {1'b0, b[SCALAR_W-1:0]};

   // overflow when both operands share a sign that the sum does not
   assign of8  = (a[7] == b[7]) && (sum8[7] != a[7]);
   assign of16 = (a[15] == b[15]) && (sum16[15] != a[15]);
   assign of32 = (a[SCALAR_W-1] == b[SCALAR_W-1]) && (sum32[SCALAR_W-1] != a[SCALAR_W-1]);

   assign nibble_sum = {1'b0, a[3:0]} + {1'b0, b[3:0]};

   always_comb begin
      flags          = '0;
      flags[FLAG_AF] = nibble_sum[4];   // same for every size
      case (opsize)
         SIZE_8: begin
            result         = OPERAND_W'(sum8[7:0]);
            flags[FLAG_OF] = of8;
            flags[FLAG_SF] = sum8[7];
            flags[FLAG_ZF] = (sum8[7:0] == 8'h00);
            flags[FLAG_CF] = sum8[8];
         end
         SIZE_16: begin
            result         = OPERAND_W'(sum16[15:0]);
            flags[FLAG_OF] = of16;
            flags[FLAG_SF] = sum16[15];
            flags[FLAG_ZF] = (sum16[15:0] == 16'h0000);
            flags[FLAG_CF] = sum16[16];
         end
         default: begin
            result         = OPERAND_W'(sum32[SCALAR_W-1:0]);
            flags[FLAG_OF] = of32;
            flags[FLAG_SF] = sum32[SCALAR_W-1];
            flags[FLAG_ZF] = (sum32[SCALAR_W-1:0] == '0);
            flags[FLAG_CF] = sum32[SCALAR_W];
         end
      endcase
   end

   // add touches every flag, PF is filled in by the result stage
   assign flag_mask = '1;

endmodule

/* design/alu_logic.sv */
`timescale 1ns/10ps

module alu_logic import alu_pkg::*; (
   input  operand_t a,
   input  operand_t b,
   input  opsize_e  opsize,
   input  alu_op_e  alu_op,
   output operand_t result,
   output eflags_t  flags,
   output eflags_t  flag_mask
);

   operand_t raw;
   operand_t size_mask;
   logic     sign_bit;

   always_comb begin
      case (alu_op)
         OR:      raw = a | b;
         NOT:     raw = ~a;
         default: raw = a & b;
      endcase
   end

   always_comb begin
      case (opsize)
         SIZE_8:  size_mask = OPERAND_W'(8'hff);
         SIZE_16: size_mask = OPERAND_W'(16'hffff);
         default: size_mask = OPERAND_W'({SCALAR_W{1'b1}});
      endcase
   end

   assign result = raw & size_mask;   // zero extended to 64

   always_comb begin
      case (opsize)
         SIZE_8:  sign_bit = result[7];
         SIZE_16: sign_bit = result[15];
         default: sign_bit = result[SCALAR_W-1];
      endcase
   end

   // OF and CF are always cleared, AF is left alone
   always_comb begin
      flags          = '0;
      flags[FLAG_SF] = sign_bit;
      flags[FLAG_ZF] = (result == '0);
      flag_mask      = '0;
      if (alu_op != NOT) begin
         flag_mask          = '1;
         flag_mask[FLAG_AF] = 1'b0;
      end
   end

endmodule

/* design/alu_shift.sv */
`timescale 1ns/10ps

module alu_shift import alu_pkg::*; (
   input  operand_t a,
   input  operand_t b,
   input  alu_op_e  alu_op,
   output operand_t result,
   output eflags_t  flags,
   output eflags_t  flag_mask
);

   logic [SHIFT_COUNT_W-1:0] count;
   logic [SCALAR_W:0]        left_ext;    // extra msb catches the bit shifted out
   logic [SCALAR_W:0]        right_ext;   // extra lsb catches the bit shifted out
   logic [SCALAR_W-1:0]      shifted;
   logic                     carry;
   logic                     is_sar;
   logic                     count_zero;
   logic                     count_one;

   assign count  = b[SHIFT_COUNT_W-1:0];
   assign is_sar = (alu_op == SAR);

   assign left_ext  = {1'b0, a[SCALAR_W-1:0]} << count;
   assign right_ext = $signed({a[SCALAR_W-1:0], 1'b0}) >>> count;   // sign fills from the top

   always_comb begin
      if (is_sar) begin
         shifted = right_ext[SCALAR_W:1];
         carry   = right_ext[0];
      end else begin
         shifted = left_ext[SCALAR_W-1:0];
         carry   = left_ext[SCALAR_W];
      end
   end

   assign count_zero = (count == '0);
   assign count_one  = (count == SHIFT_COUNT_W'(1));

   // a zero count leaves a[31:0] untouched, so no special case on the data
   assign result = OPERAND_W'(shifted);

   always_comb begin
      flags          = '0;
      flags[FLAG_SF] = shifted[SCALAR_W-1];
      flags[FLAG_ZF] = (shifted == '0);
      flags[FLAG_CF] = carry;
      // OF only defined for single-bit shifts; SAR always clears it
      flags[FLAG_OF] = count_one && !is_sar && (shifted[SCALAR_W-1] ^ carry);
   end

   always_comb begin
      flag_mask = '0;
      if (!count_zero) begin
         flag_mask[FLAG_SF] = 1'b1;
         flag_mask[FLAG_ZF] = 1'b1;
         flag_mask[FLAG_CF] = 1'b1;
         flag_mask[FLAG_PF] = 1'b1;
         flag_mask[FLAG_OF] = count_one;
      end
   end

endmodule

/* design/alu_simd.sv */
`timescale 1ns/10ps

module alu_simd import alu_pkg::*; (
   input  operand_t a,
   input  operand_t b,
   input  alu_op_e  alu_op,
   output operand_t result
);

   localparam int N16 = OPERAND_W / LANE16_W;
   localparam int N32 = OPERAND_W / LANE32_W;

   operand_t paddw_out;
   operand_t paddd_out;
   operand_t compare_out;
   logic     pick_min;

   // bit 2 tells PMAX (15) from PMIN (11)
   assign pick_min = ~alu_op[2];

   // lane adders wrap, no carry leaves a lane
   for (genvar i = 0; i < N16; i++) begin : g_addw
      assign paddw_out[i*LANE16_W +: LANE16_W] =
         a[i*LANE16_W +: LANE16_W] + b[i*LANE16_W +: LANE16_W];
   end

   for (genvar i = 0; i < N32; i++) begin : g_addd
      assign paddd_out[i*LANE32_W +: LANE32_W] =
         a[i*LANE32_W +: LANE32_W] + b[i*LANE32_W +: LANE32_W];
   end

   for (genvar i = 0; i < N16; i++) begin : g_cmp
      logic [LANE16_W-1:0] a_lane;
      logic [LANE16_W-1:0] b_lane;
      logic                b_larger;
      logic                take_b;

      assign a_lane   = a[i*LANE16_W +: LANE16_W];
      assign b_lane   = b[i*LANE16_W +: LANE16_W];
      assign b_larger = (b_lane > a_lane);   // unsigned compare
      assign take_b   = b_larger ^ pick_min;  // equal lanes give the same value either way

      assign compare_out[i*LANE16_W +: LANE16_W] = take_b ? b_lane : a_lane;
   end

   always_comb begin
      case (alu_op)
         PADDW:   result = paddw_out;
         PADDD:   result = paddd_out;
         default: result = compare_out;   // PMIN, PMAX
      endcase
   end

endmodule

/* design/alu_result_stage.sv */
`timescale 1ns/10ps

module alu_result_stage import alu_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     valid,
   input  alu_op_e  alu_op,
   input  operand_t arith_result,
   input  eflags_t  arith_flags,
   input  eflags_t  arith_mask,
   input  operand_t logic_result,
   input  eflags_t  logic_flags,
   input  eflags_t  logic_mask,
   input  operand_t shift_result,
   input  eflags_t  shift_flags,
   input  eflags_t  shift_mask,
   input  operand_t simd_result,
   input  operand_t a,
   input  operand_t b,
   output logic     out_valid,
   output operand_t alu_out,
   output eflags_t  set_eflags,
   output eflags_t  eflags_out
);

   operand_t sel_result;
   eflags_t  sel_flags;
   eflags_t  sel_mask;
   eflags_t  next_flags;
   eflags_t  next_mask;
   logic     parity_even;

   always_comb begin
      sel_result = '0;   // free opcodes fall through as zero
      sel_flags  = '0;
      sel_mask   = '0;
      case (alu_op)
         PASS_A: sel_result = a;
         PASS_B: sel_result = b;
         ADD: begin
            sel_result = arith_result;
            sel_flags  = arith_flags;
            sel_mask   = arith_mask;
         end
         AND, OR, NOT: begin
            sel_result = logic_result;
            sel_flags  = logic_flags;
            sel_mask   = logic_mask;
         end
         SAL, SAR: begin
            sel_result = shift_result;
            sel_flags  = shift_flags;
            sel_mask   = shift_mask;
         end
         PADDW, PADDD, PMIN, PMAX: sel_result = simd_result;   // packed ops leave flags alone
         default: sel_result = '0;
      endcase
   end

   // even parity over the low byte of the result
   assign parity_even = ~^sel_result[7:0];

   always_comb begin
      next_mask          = sel_mask;
      next_mask[FLAG_PF] = |sel_mask;
      next_flags          = sel_flags;
      next_flags[FLAG_PF] = parity_even;
      next_flags          = next_flags & next_mask;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid  <= 1'b0;
         set_eflags <= '0;
         eflags_out <= '0;
      end else begin
         out_valid <= valid;
         if (valid) begin
            set_eflags <= next_mask;
            eflags_out <= next_flags;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (valid) alu_out <= sel_result;   // holds while out_valid is low
   end

endmodule

/* design/alu_top.sv */
`timescale 1ns/10ps

module alu_top import alu_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   input  alu_op_e  alu_op,
   input  opsize_e  opsize,
   input  operand_t a,
   input  operand_t b,
   output logic     out_valid,
   output operand_t alu_out,
   output eflags_t  set_eflags,
   output eflags_t  eflags_out
);

   logic     valid_q;
   alu_op_e  alu_op_q;
   opsize_e  opsize_q;
   operand_t a_q;
   operand_t b_q;

   operand_t arith_result;
   eflags_t  arith_flags;
   eflags_t  arith_mask;
   operand_t logic_result;
   eflags_t  logic_flags;
   eflags_t  logic_mask;
   operand_t shift_result;
   eflags_t  shift_flags;
   eflags_t  shift_mask;
   operand_t simd_result;

   // input register, first of the two stages
   always_ff @(posedge clk) begin
      if (reset) valid_q <= 1'b0;
      else       valid_q <= in_valid;
   end

   always_ff @(posedge clk) begin
      alu_op_q <= alu_op;
      opsize_q <= opsize;
      a_q      <= a;
      b_q      <= b;
   end

   alu_arith alu_arith_inst (
      .a(a_q), .b(b_q), .opsize(opsize_q),
      .result(arith_result), .flags(arith_flags), .flag_mask(arith_mask)
   );

   alu_logic alu_logic_inst (
      .a(a_q), .b(b_q), .opsize(opsize_q), .alu_op(alu_op_q),
      .result(logic_result), .flags(logic_flags), .flag_mask(logic_mask)
   );

   alu_shift alu_shift_inst (
      .a(a_q), .b(b_q), .alu_op(alu_op_q),
      .result(shift_result), .flags(shift_flags), .flag_mask(shift_mask)
   );

   alu_simd alu_simd_inst (
      .a(a_q), .b(b_q), .alu_op(alu_op_q), .result(simd_result)
   );

   alu_result_stage alu_result_stage_inst (
      .clk(clk), .reset(reset), .valid(valid_q), .alu_op(alu_op_q),
      .arith_result(arith_result), .arith_flags(arith_flags), .arith_mask(arith_mask),
      .logic_result(logic_result), .logic_flags(logic_flags), .logic_mask(logic_mask),
      .shift_result(shift_result), .shift_flags(shift_flags), .shift_mask(shift_mask),
      .simd_result(simd_result), .a(a_q), .b(b_q),
      .out_valid(out_valid), .alu_out(alu_out),
      .set_eflags(set_eflags), .eflags_out(eflags_out)
   );

endmodule

/* testbench/alu_ref_model.svh */
// next state of the 32-bit Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
   if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
   return state >> 1;
endfunction

function automatic logic even_parity(input logic [7:0] value);
   int ones;
   ones = 0;
   for (int i = 0; i < 8; i++)
      ones += int'(value[i]);
   return (ones % 2) == 0;
endfunction

// expected result, flag mask and flag values for one item
function automatic void alu_ref(input alu_op_e op, input opsize_e size,
                                input operand_t op_a, input operand_t op_b,
                                output operand_t res, output eflags_t mask,
                                output eflags_t flags);
   int          n;
   int          cnt;
   int          sign_pos;
   operand_t    size_bits;
   logic [64:0] wide;
   logic [31:0] a32;
   logic [15:0] la;
   logic [15:0] lb;
   longint      sa;
   longint      sb;
   longint      ssum;
   longint      half;

   res   = '0;
   mask  = '0;
   flags = '0;
   case (size)
      SIZE_8:  n = 8;
      SIZE_16: n = 16;
      default: n = 32;   // any other size code means 32
   endcase
   size_bits = (64'd1 << n) - 64'd1;
   sign_pos  = n - 1;
   case (op)
      PASS_A: res = op_a;
      PASS_B: res = op_b;
      ADD: begin
         wide = {1'b0, op_a & size_bits} + {1'b0, op_b & size_bits};
         res  = wide[63:0] & size_bits;
         flags[FLAG_CF] = wide[n];
         // signed sum out of the n-bit two's complement range
         half = longint'(1) << (n - 1);
         sa   = longint'(op_a & size_bits);
         sb   = longint'(op_b & size_bits);
         if (sa >= half)
            sa = sa - 2 * half;
         if (sb >= half)
            sb = sb - 2 * half;
         ssum = sa + sb;
         flags[FLAG_OF] = (ssum >= half) || (ssum < -half);
         flags[FLAG_AF] = (int'(op_a[3:0]) + int'(op_b[3:0])) > 15;
         mask = 6'b11_1111;
      end
      AND, OR: begin
         res = ((op == AND) ? (op_a & op_b) : (op_a | op_b)) & size_bits;
         mask = 6'b11_1011;   // all but AF, OF and CF stay 0
      end
      NOT: res = ~op_a & size_bits;
      SAL, SAR: begin
         cnt      = int'(op_b[4:0]);
         a32      = op_a[31:0];
         sign_pos = 31;
         if (cnt == 0) begin
            res = {32'b0, a32};
         end else if (op == SAL) begin
            res = {32'b0, a32 << cnt};
            flags[FLAG_CF] = a32[32-cnt];   // last bit out of the top
            flags[FLAG_OF] = (cnt == 1) && (res[31] ^ a32[32-cnt]);
         end else begin
            res = {32'b0, $signed(a32) >>> cnt};
            flags[FLAG_CF] = a32[cnt-1];
         end
         if (cnt != 0)
            mask = {(cnt == 1), 5'b11_011};
      end
      PADDW: for (int i = 0; i < 4; i++) res[i*16 +: 16] = op_a[i*16 +: 16] + op_b[i*16 +: 16];
      PADDD: for (int i = 0; i < 2; i++) res[i*32 +: 32] = op_a[i*32 +: 32] + op_b[i*32 +: 32];
      PMAX, PMIN: begin
         for (int i = 0; i < 4; i++) begin
            la = op_a[i*16 +: 16];
            lb = op_b[i*16 +: 16];
            if (op == PMAX)
               res[i*16 +: 16] = (la > lb) ? la : lb;
            else
               res[i*16 +: 16] = (la < lb) ? la : lb;
         end
      end
      default: res = '0;   // free codes
   endcase
   if (mask != '0) begin
      flags[FLAG_SF] = res[sign_pos];
      flags[FLAG_ZF] = (res == '0);
      flags[FLAG_PF] = even_parity(res[7:0]);
   end
   flags = flags & mask;
endfunction

task automatic check_operand(input string name, input operand_t got, input operand_t exp);
   if (got !== exp) begin
      $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic check_eflags(input string name, input eflags_t got, input eflags_t exp);
   if (got !== exp) begin
      $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

/* testbench/alu_tb.sv */
`timescale 1ns/10ps

module alu_tb import alu_pkg::*; ();

   localparam int CLK_PERIOD     = 20;
   localparam int DRIVE_DELAY    = 2;
   localparam int DIRECTED_ITEMS = 61;
   localparam int RANDOM_ITEMS   = 2000;
   localparam int WATCH_CYCLES   = DIRECTED_ITEMS + RANDOM_ITEMS + 20;

   logic     clk;
   logic     reset;
   logic     in_valid;
   alu_op_e  alu_op;
   opsize_e  opsize;
   operand_t a;
   operand_t b;
   logic     out_valid;
   operand_t alu_out;
   eflags_t  set_eflags;
   eflags_t  eflags_out;

   operand_t    exp_result_q[$];
   eflags_t     exp_mask_q[$];
   eflags_t     exp_flags_q[$];
   int          exp_cycle_q[$];
   int          cycle_count = 0;
   logic [31:0] lfsr_state = 32'hf22e_4bb6;
   logic        have_last = 1'b0;
   operand_t    last_result;
   eflags_t     last_mask;
   eflags_t     last_flags;
   int          want_cycle;

   alu_top alu_top_inst (
      .clk(clk), .reset(reset), .in_valid(in_valid), .alu_op(alu_op), .opsize(opsize),
      .a(a), .b(b), .out_valid(out_valid), .alu_out(alu_out),
      .set_eflags(set_eflags), .eflags_out(eflags_out)
   );

   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   `include "alu_ref_model.svh"

   // one LFSR step per bit taken, bits shift in from the bottom
   function automatic logic [63:0] take_bits(input int count);
      logic [63:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         value      = {value[62:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return value;
   endfunction

   task automatic send_item(input alu_op_e op, input opsize_e size,
                            input operand_t op_a, input operand_t op_b);
      operand_t res;
      eflags_t  mask;
      eflags_t  flags;
      @(posedge clk);
      #DRIVE_DELAY;
      in_valid = 1'b1;
      alu_op   = op;
      opsize   = size;
      a        = op_a;
      b        = op_b;
      alu_ref(op, size, op_a, op_b, res, mask, flags);
      exp_result_q.push_back(res);
      exp_mask_q.push_back(mask);
      exp_flags_q.push_back(flags);
      exp_cycle_q.push_back(cycle_count + 2);   // input reg then output reg
   endtask

   // junk on the operands while nothing is valid
   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         #DRIVE_DELAY;
         in_valid = 1'b0;
         a        = take_bits(64);
         b        = take_bits(64);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) cycle_count <= cycle_count + 1;

   // outputs are sampled on the falling edge, well clear of the register updates
   always @(negedge clk) begin
      if (!reset && out_valid) begin
         if (exp_result_q.size() == 0) begin
            $display("out_valid went high with no item in flight");
            abort_run();
         end else begin
            want_cycle = exp_cycle_q.pop_front();
            if (want_cycle != cycle_count) begin
               $display("item came out at cycle %0d instead of cycle %0d", cycle_count, want_cycle);
               abort_run();
            end
            last_result = exp_result_q.pop_front();
            last_mask   = exp_mask_q.pop_front();
            last_flags  = exp_flags_q.pop_front();
            have_last   = 1'b1;
            check_operand("alu_out", alu_out, last_result);
            check_eflags("set_eflags", set_eflags, last_mask);
            check_eflags("eflags_out", eflags_out, last_flags);
         end
      end else if (!reset && have_last) begin
         check_operand("alu_out", alu_out, last_result);   // must hold
         check_eflags("set_eflags", set_eflags, last_mask);
         check_eflags("eflags_out", eflags_out, last_flags);
      end
   end

   initial begin
      #(WATCH_CYCLES * CLK_PERIOD);
      $display("timeout, the run took longer than %0d cycles", WATCH_CYCLES);
      abort_run();
   end

   initial begin
      operand_t    ra;
      operand_t    rb;
      operand_t    size_max;
      operand_t    sign;
      operand_t    junk;
      alu_op_e     logic_ops [5];
      int          shift_counts [5];
      logic [3:0]  free_codes [4];
      int          n;

      reset    = 1'b1;
      in_valid = 1'b0;
      alu_op   = PASS_A;
      opsize   = SIZE_32;
      a        = '0;
      b        = '0;
      repeat (3) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);
      check_eflags("set_eflags", set_eflags, '0);
      check_eflags("eflags_out", eflags_out, '0);

      // ADD carry, overflow, zero and half carry at each size, upper bits junk
      for (int s = 1; s <= 3; s++) begin
         n        = 4 << s;
         size_max = (64'd1 << n) - 64'd1;
         sign     = 64'd1 << (n - 1);
         junk     = ~size_max & 64'h96e1_5a3c_c3a5_1e69;
         send_item(ADD, opsize_e'(3'(s)), size_max | junk, 64'd1);
         send_item(ADD, opsize_e'(3'(s)), (sign - 64'd1) | junk, 64'd1 | ~size_max);
         send_item(ADD, opsize_e'(3'(s)), sign | junk, sign);
         send_item(ADD, opsize_e'(3'(s)), 64'h0f | junk, 64'h01);
         send_item(ADD, opsize_e'(3'(s)), junk, ~size_max);
      end
      idle(1);

      logic_ops = '{AND, OR, NOT, PASS_A, PASS_B};
      for (int k = 0; k < 5; k++) begin
         for (int s = 0; s < 4; s++) begin   // size code 0 runs as 32 bits
            ra = take_bits(64);
            rb = (s == 2) ? ~ra : take_bits(64);
            send_item(logic_ops[k], opsize_e'(3'(s)), ra, rb);
         end
      end
      idle(1);

      shift_counts = '{0, 1, 31, 0, 0};
      for (int k = 0; k < 10; k++) begin
         ra     = take_bits(64);
         ra[31] = k[0];
         rb     = take_bits(64);
         rb[4:0] = (k % 5 < 3) ? 5'(shift_counts[k % 5]) : 5'(take_bits(5));
         send_item((k < 5) ? SAL : SAR, SIZE_32, ra, rb);
      end
      idle(1);

      // lane carries, equal lanes, then random lanes
      for (int k = 0; k < 12; k++) begin
         case (k % 3)
            0: begin
               ra = 64'hffff_8000_7fff_0001;
               rb = 64'h0001_8000_0001_ffff;
            end
            1: begin
               ra = 64'h1234_ffff_0000_8001;
               rb = ra;
            end
            default: begin
               ra = take_bits(64);
               rb = take_bits(64);
            end
         endcase
         case (k / 3)
            0:       send_item(PADDW, SIZE_32, ra, rb);
            1:       send_item(PADDD, SIZE_32, ra, rb);
            2:       send_item(PMAX, SIZE_32, ra, rb);
            default: send_item(PMIN, SIZE_32, ra, rb);
         endcase
      end
      free_codes = '{4'd3, 4'd5, 4'd6, 4'd14};
      for (int k = 0; k < 4; k++)
         send_item(alu_op_e'(free_codes[k]), opsize_e'(3'(take_bits(3))), take_bits(64), ~ra);
      idle(1);

      // back to back random items over every code and size
      repeat (RANDOM_ITEMS) begin
         ra = take_bits(64);
         rb = take_bits(64);
         send_item(alu_op_e'(4'(take_bits(4))), opsize_e'(3'(take_bits(3))), ra, rb);
      end
      idle(4);
      @(negedge clk);

      if (exp_result_q.size() != 0) begin
         $display("%0d items were accepted but never came out", exp_result_q.size());
         abort_run();
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

/* flist.f */
+incdir+testbench
design/alu_pkg.sv
design/alu_arith.sv
design/alu_logic.sv
design/alu_shift.sv
design/alu_simd.sv
design/alu_result_stage.sv
design/alu_top.sv
testbench/alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute unit testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timescale 1ns/10ps --top-module alu_tb -f flist.f \
   --Mdir obj_dir -o alu_tb_sim > sim.log 2>&1 \
   || { echo "verilator build failed, see sim.log"; exit 1; }

./obj_dir/alu_tb_sim >> sim.log 2>&1 || echo "simulator exited with an error status"

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
